//--- build.f
+incdir+include
logic/stream_pkg.sv
logic/buffer_pkg.sv
logic/stream_queue.sv
logic/occupancy_counter.sv
logic/packet_release_gate.sv
logic/packet_buffer.sv
verification/packet_buffer_tb.sv

//--- include/pkt_buf_cfg.svh
// Build-time sizes for the store-and-forward packet buffer
// include it wherever beat widths or the queue capacity are needed

`ifndef PKT_BUF_CFG_SVH
`define PKT_BUF_CFG_SVH

// payload bits carried by one beat, one byte per beat on this link
`define PKT_BUF_DATA_WIDTH 8

// sideband bits that travel alongside each payload byte
`define PKT_BUF_USER_WIDTH 4

// beats the internal queue can hold, a power of two keeps the pointers simple
// a packet longer than this is released early through the escape path
`define PKT_BUF_CAPACITY 16

`endif

//--- logic/buffer_pkg.sv
// Bookkeeping types used inside the packet buffer
// covers occupancy counts, queue slot addresses and the release gate FSM

`include "pkt_buf_cfg.svh"

package buffer_pkg;

    typedef logic [$clog2(`PKT_BUF_CAPACITY+1)-1:0] fill_count_t;  // 0 up to full capacity

    typedef logic [$clog2(`PKT_BUF_CAPACITY)-1:0] queue_index_t;   // one slot of the queue memory

    typedef enum logic [1:0] {
        GATE_HOLD   = 2'd0,  // output blocked, nothing leaves
        GATE_PACKET = 2'd1,  // a fully stored packet is draining
        GATE_ESCAPE = 2'd2   // oversize packet drains before its end arrived
    } gate_state_t;

endpackage

//--- logic/occupancy_counter.sv
// Up/down count of beats or whole packets held between two stream handshake points
// set COUNT_PACKETS to 1 so that only beats carrying last are counted

`timescale 1ns/1ps

`include "pkt_buf_cfg.svh"

module occupancy_counter
    import buffer_pkg::*;
#(
    parameter bit COUNT_PACKETS = 1'b0  // 0 counts beats, 1 counts complete packets
) (
    input  logic        aclk,
    input  logic        rst,
    input  logic        add_valid,  // handshake where items enter
    input  logic        add_ready,
    input  logic        add_last,
    input  logic        sub_valid,  // handshake where items leave
    input  logic        sub_ready,
    input  logic        sub_last,
    output fill_count_t count
);
    localparam fill_count_t MAX_COUNT = fill_count_t'(`PKT_BUF_CAPACITY);

    logic add_hit;  // one item enters on this edge
    logic sub_hit;  // one item leaves on this edge

    // in beat mode the last marker is ignored and every transfer counts
    assign add_hit = add_valid && add_ready && (add_last || !COUNT_PACKETS);
    assign sub_hit = sub_valid && sub_ready && (sub_last || !COUNT_PACKETS);

    always_ff @(posedge aclk) begin
        if (rst) begin
            count <= '0;
        end else begin
            case ({add_hit, sub_hit})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // simultaneous in and out cancel
            endcase
        end
    end

    // the queue behind this counter can never hold more than its capacity
    a_count_bounded: assert property (@(posedge aclk) disable iff (rst)
        count <= MAX_COUNT)
        else $error("occupancy_counter count %0d passed capacity", count);

    // nothing can leave that was never counted in
    a_no_underflow: assert property (@(posedge aclk) disable iff (rst)
        sub_hit && !add_hit |-> count != '0)
        else $error("occupancy_counter decremented below zero");

endmodule

//--- logic/packet_buffer.sv
// Store-and-forward packet buffer for the byte stream link
// beats are queued and released downstream one complete packet at a time

`timescale 1ns/1ps

`include "pkt_buf_cfg.svh"

module packet_buffer
    import stream_pkg::*, buffer_pkg::*;
(
    input  logic       aclk,
    input  logic       rst,
    input  logic       in_tvalid,
    output logic       in_tready,
    input  beat_data_t in_tdata,
    input  beat_user_t in_tuser,
    input  logic       in_tlast,
    output logic       out_tvalid,
    input  logic       out_tready,
    output beat_data_t out_tdata,
    output beat_user_t out_tuser,
    output logic       out_tlast
);
    logic        q_tvalid;      // queue read side towards the gate
    logic        q_tready;
    beat_data_t  q_tdata;
    beat_user_t  q_tuser;
    logic        q_tlast;
    fill_count_t beats_held;    // every beat between in and out
    fill_count_t packets_held;  // complete packets between in and out

    stream_queue #(
        .DEPTH(`PKT_BUF_CAPACITY)
    ) queue (
        .aclk(aclk), .rst(rst),
        .in_tvalid(in_tvalid), .in_tready(in_tready),
        .in_tdata(in_tdata), .in_tuser(in_tuser), .in_tlast(in_tlast),
        .q_tvalid(q_tvalid), .q_tready(q_tready),
        .q_tdata(q_tdata), .q_tuser(q_tuser), .q_tlast(q_tlast)
    );

    occupancy_counter #(
        .COUNT_PACKETS(1'b0)
    ) beat_count (
        .aclk(aclk), .rst(rst),
        .add_valid(in_tvalid), .add_ready(in_tready), .add_last(in_tlast),
        .sub_valid(out_tvalid), .sub_ready(out_tready), .sub_last(out_tlast),
        .count(beats_held)
    );

    occupancy_counter #(
        .COUNT_PACKETS(1'b1)
    ) packet_count (
        .aclk(aclk), .rst(rst),
        .add_valid(in_tvalid), .add_ready(in_tready), .add_last(in_tlast),
        .sub_valid(out_tvalid), .sub_ready(out_tready), .sub_last(out_tlast),
        .count(packets_held)
    );

    packet_release_gate gate (
        .aclk(aclk), .rst(rst),
        .q_tvalid(q_tvalid), .q_tready(q_tready),
        .q_tdata(q_tdata), .q_tuser(q_tuser), .q_tlast(q_tlast),
        .packets_held(packets_held), .beats_held(beats_held),
        .out_tvalid(out_tvalid), .out_tready(out_tready),
        .out_tdata(out_tdata), .out_tuser(out_tuser), .out_tlast(out_tlast)
    );

endmodule

//--- logic/packet_release_gate.sv
// Holds the queue output back until a complete packet is stored
// also opens early when a full queue holds no complete packet, so oversize packets cannot stall

`timescale 1ns/1ps

`include "pkt_buf_cfg.svh"

module packet_release_gate
    import stream_pkg::*, buffer_pkg::*;
(
    input  logic        aclk,
    input  logic        rst,
    input  logic        q_tvalid,
    output logic        q_tready,
    input  beat_data_t  q_tdata,
    input  beat_user_t  q_tuser,
    input  logic        q_tlast,
    input  fill_count_t packets_held,  // complete packets between input and output
    input  fill_count_t beats_held,    // beats between input and output
    output logic        out_tvalid,
    input  logic        out_tready,
    output beat_data_t  out_tdata,
    output beat_user_t  out_tuser,
    output logic        out_tlast
);
    localparam fill_count_t FULL_COUNT = fill_count_t'(`PKT_BUF_CAPACITY);

    gate_state_t state;       // current release mode
    gate_state_t state_next;
    logic        gate_open;   // a packet is allowed to drain
    logic        last_fire;   // final beat of the draining packet leaves

    assign gate_open = (state != GATE_HOLD);

    // straight pass-through while open, both directions blocked while holding
    assign out_tvalid = q_tvalid && gate_open;
    assign q_tready   = out_tready && gate_open;
    assign out_tdata  = q_tdata;
    assign out_tuser  = q_tuser;
    assign out_tlast  = q_tlast;

    assign last_fire = out_tvalid && out_tready && out_tlast;

    always_comb begin
        state_next = state;
        case (state)
            GATE_HOLD: begin
                if (packets_held != '0) begin
                    state_next = GATE_PACKET;  // head packet is complete in the queue
                end else if (beats_held == FULL_COUNT) begin
                    state_next = GATE_ESCAPE;  // queue full of one unfinished packet
                end
            end
            GATE_PACKET, GATE_ESCAPE: begin
                if (last_fire) begin
                    state_next = GATE_HOLD;  // decide again for the next packet
                end
            end
            default: state_next = GATE_HOLD;
        endcase
    end

    always_ff @(posedge aclk) begin
        if (rst) begin
            state <= GATE_HOLD;
        end else begin
            state <= state_next;
        end
    end

    a_hold_blocks_output: assert property (@(posedge aclk) disable iff (rst)
        state == GATE_HOLD |-> !out_tvalid)
        else $error("packet_release_gate offered a beat while holding");

    // a normal release only drains while the packet counter still sees a stored packet
    a_packet_is_stored: assert property (@(posedge aclk) disable iff (rst)
        state == GATE_PACKET && out_tvalid |-> packets_held != '0)
        else $error("packet_release_gate released a packet that was not stored");

endmodule

//--- logic/stream_pkg.sv
// Field types of one beat on the byte stream link
// imported by every block that carries or stores beats

`include "pkt_buf_cfg.svh"

package stream_pkg;

    // payload of a single beat, sized by the shared config
    typedef logic [`PKT_BUF_DATA_WIDTH-1:0] beat_data_t;

    // user sideband that rides with each beat unchanged
    typedef logic [`PKT_BUF_USER_WIDTH-1:0] beat_user_t;

endpackage

//--- logic/stream_queue.sv
// FIFO for stream beats with valid/ready on both the write and the read side
// the read side is a registered output stage so a beat can enter and leave each cycle

`timescale 1ns/1ps

`include "pkt_buf_cfg.svh"

module stream_queue
    import stream_pkg::*, buffer_pkg::*;
#(
    parameter int DEPTH = `PKT_BUF_CAPACITY  // must not exceed the capacity the index type covers
) (
    input  logic       aclk,
    input  logic       rst,
    input  logic       in_tvalid,
    output logic       in_tready,
    input  beat_data_t in_tdata,
    input  beat_user_t in_tuser,
    input  logic       in_tlast,
    output logic       q_tvalid,
    input  logic       q_tready,
    output beat_data_t q_tdata,
    output beat_user_t q_tuser,
    output logic       q_tlast
);
    localparam queue_index_t LAST_SLOT  = queue_index_t'(DEPTH - 1);  // wrap point of both pointers
    localparam fill_count_t  FULL_COUNT = fill_count_t'(DEPTH);

    beat_data_t   mem_data [DEPTH];  // payload storage
    beat_user_t   mem_user [DEPTH];  // sideband storage, same slot as its payload
    logic         mem_last [DEPTH];  // end-of-packet marker per slot
    queue_index_t wr_ptr;            // next slot to be written
    queue_index_t rd_ptr;            // oldest slot not yet moved to the output stage
    fill_count_t  fill;              // beats held in memory plus the output stage
    fill_count_t  mem_fill;          // beats still sitting in memory
    logic         wr_fire;           // write handshake on this edge
    logic         rd_fire;           // output stage hands its beat over on this edge
    logic         out_free;          // output stage empty or being emptied
    logic         load;              // memory head moves into the output stage
    logic         bypass;            // incoming beat goes straight to the output stage

    // advance a pointer by one slot and wrap at DEPTH
    function automatic queue_index_t next_slot(input queue_index_t ptr);
        return (ptr == LAST_SLOT) ? '0 : queue_index_t'(ptr + 1'b1);
    endfunction

    assign in_tready = (fill != FULL_COUNT);              // low exactly when every slot is taken
    assign wr_fire   = in_tvalid && in_tready;
    assign rd_fire   = q_tvalid && q_tready;
    assign mem_fill  = fill - fill_count_t'(q_tvalid);    // output stage holds at most one beat
    assign out_free  = !q_tvalid || q_tready;
    assign load      = out_free && (mem_fill != '0);      // memory order always goes first
    assign bypass    = out_free && (mem_fill == '0) && wr_fire;

    always_ff @(posedge aclk) begin
        if (wr_fire && !bypass) begin  // beat has to wait behind older ones
            mem_data[wr_ptr] <= in_tdata;
            mem_user[wr_ptr] <= in_tuser;
            mem_last[wr_ptr] <= in_tlast;
        end
    end

    always_ff @(posedge aclk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (wr_fire && !bypass) begin
                wr_ptr <= next_slot(wr_ptr);
            end
            if (load) begin
                rd_ptr <= next_slot(rd_ptr);
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (rst) begin
            fill <= '0;
        end else begin
            case ({wr_fire, rd_fire})
                2'b10:   fill <= fill + 1'b1;  // beat in, nothing out
                2'b01:   fill <= fill - 1'b1;  // beat out, nothing in
                default: fill <= fill;         // both or neither leave the total alone
            endcase
        end
    end

    always_ff @(posedge aclk) begin
        if (rst) begin
            q_tvalid <= 1'b0;
        end else if (out_free) begin
            q_tvalid <= load || bypass;  // refill whenever anything is available
        end
    end

    always_ff @(posedge aclk) begin
        if (load) begin  // registered read of the memory head
            q_tdata <= mem_data[rd_ptr];
            q_tuser <= mem_user[rd_ptr];
            q_tlast <= mem_last[rd_ptr];
        end else if (bypass) begin  // empty queue gives one cycle latency
            q_tdata <= in_tdata;
            q_tuser <= in_tuser;
            q_tlast <= in_tlast;
        end
    end

    // equal pointers mean an empty or a full memory, and only the empty one may take a write
    a_no_write_when_full: assert property (@(posedge aclk) disable iff (rst)
        wr_fire && !bypass && (wr_ptr == rd_ptr) |-> (mem_fill == '0))
        else $error("stream_queue wrote over an unread beat while full");

    // offered beat must hold until the gate takes it
    a_output_stable: assert property (@(posedge aclk) disable iff (rst)
        q_tvalid && !q_tready |=> q_tvalid && $stable({q_tdata, q_tuser, q_tlast}))
        else $error("stream_queue changed or dropped q_tvalid before transfer");

endmodule

//--- verification/packet_buffer_tb.sv
// Testbench for the store-and-forward packet buffer with random packets and output stalls
// concurrent assertions compare the DUT against a scoreboard and occupancy model

`timescale 1ns/1ps

`include "pkt_buf_cfg.svh"

module packet_buffer_tb
    import stream_pkg::*;
;
    localparam int CAP      = `PKT_BUF_CAPACITY;
    localparam int NUM_PKTS = 36;    // packets sent in the whole run
    localparam int BIG_AT   = 20;    // index of the oversize packet
    localparam int BIG_LEN  = 24;    // longer than the queue, forces the escape path
    localparam int SB_SIZE  = 1024;  // more than the longest possible run of beats
    localparam int TIMEOUT  = 2000;  // cycles allowed for any single wait

    logic       aclk = 1'b0;
    logic       rst;
    logic       in_tvalid;
    logic       in_tready;
    beat_data_t in_tdata;
    beat_user_t in_tuser;
    logic       in_tlast;
    logic       out_tvalid;
    logic       out_tready;
    beat_data_t out_tdata;
    beat_user_t out_tuser;
    logic       out_tlast;

    int         seed = 54342;          // stimulus stream
    int         stall_seed;            // sink stream, kept apart so process order does not matter
    int         errors = 0;
    int         timeouts = 0;
    int         cur_len;               // length of the packet being driven
    logic       slow_sink = 1'b0;      // heavy back-pressure phase so the queue fills

    beat_data_t sb_data [SB_SIZE];     // scoreboard of accepted beats in order
    beat_user_t sb_user [SB_SIZE];
    logic       sb_last [SB_SIZE];
    int         sb_len  [SB_SIZE];     // length of the packet each beat belongs to
    int         sb_wr, sb_rd;          // beats entered and beats left
    int         pkts_in, pkts_out;     // complete packets entered and left
    int         big_done;              // oversize packets fully delivered
    logic       out_first;             // next output beat starts a packet
    logic       prev_hold;             // last edge saw a stalled output beat
    beat_data_t prev_data;
    beat_user_t prev_user;
    logic       prev_last;
    beat_data_t exp_data;              // oldest unchecked beat
    beat_user_t exp_user;
    logic       exp_last;
    int         exp_len;
    int         beats_model, pkts_model;

    packet_buffer dut (
        .aclk(aclk), .rst(rst),
        .in_tvalid(in_tvalid), .in_tready(in_tready),
        .in_tdata(in_tdata), .in_tuser(in_tuser), .in_tlast(in_tlast),
        .out_tvalid(out_tvalid), .out_tready(out_tready),
        .out_tdata(out_tdata), .out_tuser(out_tuser), .out_tlast(out_tlast)
    );

    always #10 aclk = ~aclk;  // 20 ns period

    always_comb begin
        exp_data    = sb_data[sb_rd];
        exp_user    = sb_user[sb_rd];
        exp_last    = sb_last[sb_rd];
        exp_len     = sb_len[sb_rd];
        beats_model = sb_wr - sb_rd;        // beats held inside the buffer
        pkts_model  = pkts_in - pkts_out;   // complete packets held inside the buffer
    end

    // reference model follows both handshakes on every edge
    always @(posedge aclk) begin
        if (rst) begin
            sb_wr     <= 0;
            sb_rd     <= 0;
            pkts_in   <= 0;
            pkts_out  <= 0;
            big_done  <= 0;
            out_first <= 1'b1;
            prev_hold <= 1'b0;
        end else begin
            if (in_tvalid && in_tready) begin
                sb_data[sb_wr] <= in_tdata;
                sb_user[sb_wr] <= in_tuser;
                sb_last[sb_wr] <= in_tlast;
                sb_len[sb_wr]  <= cur_len;
                sb_wr          <= sb_wr + 1;
                if (in_tlast) pkts_in <= pkts_in + 1;
            end
            if (out_tvalid && out_tready) begin
                sb_rd     <= sb_rd + 1;
                out_first <= out_tlast;  // a new packet follows every last beat
                if (out_tlast) begin
                    pkts_out <= pkts_out + 1;
                    if (exp_len > CAP) big_done <= big_done + 1;
                end
            end
            prev_hold <= out_tvalid && !out_tready;
            prev_data <= out_tdata;
            prev_user <= out_tuser;
            prev_last <= out_tlast;
        end
    end

    reset_idle: assert property (@(posedge aclk) $fell(rst) |-> !out_tvalid && in_tready)
        else begin
            errors++;
            $display("Error at %0t: out_tvalid or in_tready wrong after reset, got %b and %b",
                     $time, $sampled(out_tvalid), $sampled(in_tready));
        end

    no_extra_beat: assert property (@(posedge aclk) disable iff (rst) out_tvalid |-> sb_rd < sb_wr)
        else begin
            errors++;
            $display("Error at %0t: output beat offered with no beat left in the scoreboard", $time);
        end

    data_matches: assert property (@(posedge aclk) disable iff (rst)
        out_tvalid && out_tready |-> out_tdata == exp_data)
        else begin
            errors++;
            $display("Error at %0t: out_tdata expected %h, got %h",
                     $time, $sampled(exp_data), $sampled(out_tdata));
        end

    user_matches: assert property (@(posedge aclk) disable iff (rst)
        out_tvalid && out_tready |-> out_tuser == exp_user)
        else begin
            errors++;
            $display("Error at %0t: out_tuser expected %h, got %h",
                     $time, $sampled(exp_user), $sampled(out_tuser));
        end

    last_matches: assert property (@(posedge aclk) disable iff (rst)
        out_tvalid && out_tready |-> out_tlast == exp_last)
        else begin
            errors++;
            $display("Error at %0t: out_tlast expected %b, got %b",
                     $time, $sampled(exp_last), $sampled(out_tlast));
        end

    // a packet that fits may only start once the model holds a complete packet
    first_beat_stored: assert property (@(posedge aclk) disable iff (rst)
        out_tvalid && out_first && exp_len <= CAP |-> pkts_model != 0)
        else begin
            errors++;
            $display("A packet started to leave before its last beat was accepted at %0t", $time);
        end

    packet_stored: assert property (@(posedge aclk) disable iff (rst)
        out_tvalid && exp_len <= CAP |-> pkts_model != 0)
        else begin
            errors++;
            $display("A beat left before its packet was complete at %0t", $time);
        end

    // oversize packets are only released once the queue is completely full
    escape_after_full: assert property (@(posedge aclk) disable iff (rst)
        out_tvalid && out_first && exp_len > CAP |-> beats_model == CAP)
        else begin
            errors++;
            $display("Error at %0t: beats held at escape expected %0d, got %0d",
                     $time, CAP, $sampled(beats_model));
        end

    valid_held: assert property (@(posedge aclk) disable iff (rst) prev_hold |-> out_tvalid)
        else begin
            errors++;
            $display("Error at %0t: out_tvalid expected 1, got 0 while stalled", $time);
        end

    beat_held: assert property (@(posedge aclk) disable iff (rst)
        prev_hold |-> {out_tdata, out_tuser, out_tlast} == {prev_data, prev_user, prev_last})
        else begin
            errors++;
            $display("Error at %0t: stalled out beat expected %h, got %h", $time,
                     $sampled({prev_data, prev_user, prev_last}),
                     $sampled({out_tdata, out_tuser, out_tlast}));
        end

    ready_tracks_fill: assert property (@(posedge aclk) disable iff (rst)
        in_tready == (beats_model != CAP))
        else begin
            errors++;
            $display("Error at %0t: in_tready expected %b, got %b",
                     $time, $sampled(beats_model != CAP), $sampled(in_tready));
        end

    task automatic end_run();
        $display("Run finished with %0d check errors and %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    endtask

    // holds the driven beat until a negedge shows in_tready, then moves past the transfer edge
    task automatic wait_accept();
        int cycles;
        cycles = 0;
        @(negedge aclk);
        while (!in_tready) begin
            cycles++;
            if (cycles > TIMEOUT) begin
                timeouts++;
                $display("Timeout at %0t: input beat not accepted in %0d cycles", $time, TIMEOUT);
                end_run();
            end
            @(negedge aclk);
        end
        @(posedge aclk);
        #1;
    endtask

    task automatic send_packet(input int len);
        int gap;
        for (int i = 0; i < len; i++) begin
            gap = ($unsigned($random(seed)) % 4 == 0) ? 1 + $unsigned($random(seed)) % 3 : 0;
            repeat (gap) begin  // idle cycles between beats
                @(posedge aclk);
                #1;
            end
            cur_len   = len;
            in_tdata  = beat_data_t'($random(seed));
            in_tuser  = beat_user_t'($random(seed));
            in_tlast  = (i == len - 1);
            in_tvalid = 1'b1;
            wait_accept();
            in_tvalid = 1'b0;
        end
    endtask

    // waits until every packet that entered has also left through the output
    task automatic wait_drain();
        int cycles;
        cycles = 0;
        @(negedge aclk);
        while (pkts_out != pkts_in) begin
            cycles++;
            if (cycles > TIMEOUT) begin
                timeouts++;
                $display("Timeout at %0t: not all packets left the buffer in %0d cycles",
                         $time, TIMEOUT);
                end_run();
            end
            @(negedge aclk);
        end
    endtask

    // sink with random stalls, much slower during the heavy phase
    initial begin
        logic slow_now;
        stall_seed = seed + 1;
        out_tready = 1'b0;
        forever begin
            @(posedge aclk);
            slow_now = slow_sink;  // the phase flag only moves 1 ns after an edge
            #1;
            if (slow_now) out_tready = ($unsigned($random(stall_seed)) % 4) == 0;
            else out_tready = ($unsigned($random(stall_seed)) % 4) != 0;
        end
    end

    initial begin
        int len;
        rst       = 1'b1;
        in_tvalid = 1'b0;
        in_tdata  = '0;
        in_tuser  = '0;
        in_tlast  = 1'b0;
        cur_len   = 0;
        repeat (4) @(posedge aclk);
        #1;
        rst = 1'b0;
        for (int p = 0; p < NUM_PKTS; p++) begin
            slow_sink = (p >= 8 && p < 14);  // lets complete packets pile up to full
            if (p == BIG_AT) len = BIG_LEN;
            else len = 1 + $unsigned($random(seed)) % 12;
            send_packet(len);
        end
        wait_drain();
        beats_equal: assert (sb_wr == sb_rd) else begin
            errors++;
            $display("Error at %0t: beats received expected %0d, got %0d", $time, sb_wr, sb_rd);
        end
        big_delivered: assert (big_done == 1) else begin
            errors++;
            $display("Error at %0t: oversize packets delivered expected 1, got %0d",
                     $time, big_done);
        end
        idle_at_end: assert (!out_tvalid) else begin
            errors++;
            $display("Error at %0t: out_tvalid expected 0, got 1 after drain", $time);
        end
        end_run();
    end

endmodule
